/* bank_mem.sv */
/*
 * four-bank main memory, each bank busy for a while after an access,
 * with a pipelined fixed-latency read
 */
`timescale 1ns/1ns
`default_nettype none

module bank_mem #(
   parameter int BANK_BUSY = 4
) (
   input  logic                 clk,
   input  logic                 arst_n,
   input  mem_sys_pkg::mem_req_t req,
   output mem_sys_pkg::mem_rsp_t rsp
);
   import mem_sys_pkg::*;

   localparam int BANKS  = 4;
   localparam int ROW_W  = TAG_W + IDX_W;
   localparam int ROWS   = 2 ** ROW_W;
   localparam int CNT_W  = $clog2(BANK_BUSY + 1);
   localparam int BSEL_W = $clog2(BANKS);

   logic [WORD_W-1:0] mem_arr [BANKS][ROWS];
   logic [CNT_W-1:0]  busy_cnt [BANKS];
   logic [BSEL_W-1:0] bank;
   logic [ROW_W-1:0]  row;
   logic              rd_go;
   logic              wr_go;
   logic [MEM_RD_LAT-1:0] vld_pipe;
   logic [WORD_W-1:0] dat_pipe [MEM_RD_LAT];

   // bank from address bits 2:1, row from bits 15:3
   assign bank = req.addr.fields.offset[OFS_W-1:1];
   assign row  = {req.addr.fields.tag, req.addr.fields.index};

   assign rsp.stall = (busy_cnt[bank] != '0);
   assign rd_go     = req.rd & ~rsp.stall;
   assign wr_go     = req.wr & ~rsp.stall;

   assign rsp.rd_valid = vld_pipe[MEM_RD_LAT-1];
   assign rsp.rd_data  = dat_pipe[MEM_RD_LAT-1];

   // memory contents start at zero
   initial begin
      for (int b = 0; b < BANKS; b++) begin
         for (int r = 0; r < ROWS; r++) begin
            mem_arr[b][r] = '0;
         end
      end
   end

   // busy down-counters, reloaded on any accepted access
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int b = 0; b < BANKS; b++) begin
            busy_cnt[b] <= '0;
         end
      end else begin
         for (int b = 0; b < BANKS; b++) begin
            if ((rd_go || wr_go) && (bank == BSEL_W'(b))) begin
               busy_cnt[b] <= CNT_W'(BANK_BUSY);
            end else if (busy_cnt[b] != '0) begin
               busy_cnt[b] <= busy_cnt[b] - 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         vld_pipe <= '0;
      end else begin
         vld_pipe <= {vld_pipe[MEM_RD_LAT-2:0], rd_go};
      end
   end

   always_ff @(posedge clk) begin
      if (wr_go) begin
         mem_arr[bank][row] <= req.data;
      end
      // data stage follows the valid stage, captured every cycle
      dat_pipe[0] <= mem_arr[bank][row];
      for (int s = 1; s < MEM_RD_LAT; s++) begin
         dat_pipe[s] <= dat_pipe[s-1];
      end
   end

endmodule

`default_nettype wire

/* cache_ctrl.sv */
/*
 * cache controller FSM: compare, dirty writeback, line fill from memory
 * and the processor-side stall, done and err strobes
 */
`timescale 1ns/1ns
`default_nettype none

module cache_ctrl (
   input  logic                                 clk,
   input  logic                                 arst_n,
   input  mem_sys_pkg::addr_u                   addr,
   input  logic [mem_sys_pkg::WORD_W-1:0]       data_in,
   input  logic                                 rd,
   input  logic                                 wr,
   output logic [mem_sys_pkg::WORD_W-1:0]       data_out,
   output logic                                 done,
   output logic                                 stall,
   output logic                                 cache_hit,
   output logic                                 err,
   output mem_sys_pkg::cache_req_t              way_req,
   output logic                                 way0_en,
   output logic                                 way1_en,
   input  mem_sys_pkg::way_rsp_t                way0_rsp,
   input  mem_sys_pkg::way_rsp_t                way1_rsp,
   output mem_sys_pkg::mem_req_t                mem_req,
   input  mem_sys_pkg::mem_rsp_t                mem_rsp
);
   import mem_sys_pkg::*;

   localparam int WSEL_W = $clog2(LINE_WORDS);

   typedef enum logic [2:0] {
      S_IDLE, S_ERR, S_COMP, S_WB, S_ALLOC, S_FCOMP, S_DONE
   } state_t;

   state_t            state;
   state_t            state_nxt;
   addr_u             addr_q;
   logic [WORD_W-1:0] data_q;
   logic              rd_q;
   logic              wr_q;
   logic              victim_q;
   logic              way_q;
   logic              way_pick;
   logic [WSEL_W:0]   issue_cnt;
   logic [WSEL_W-1:0] fill_cnt;
   logic              accept;
   logic              any_hit;
   logic              mem_go;
   logic              issue_last;
   logic              fill_last;
   way_rsp_t          sel_rsp;

   assign stall      = (state != S_IDLE);
   assign accept     = (rd | wr) & ~stall;
   assign any_hit    = way0_rsp.hit | way1_rsp.hit;
   assign mem_go     = (mem_req.rd | mem_req.wr) & ~mem_rsp.stall;
   assign issue_last = (issue_cnt[WSEL_W-1:0] == WSEL_W'(LINE_WORDS - 1));
   assign fill_last  = (fill_cnt == WSEL_W'(LINE_WORDS - 1));

   // invalid way first, way 0 if both, else the toggling victim bit
   assign way_pick = ~way0_rsp.valid ? 1'b0 : (~way1_rsp.valid ? 1'b1 : victim_q);
   assign sel_rsp  = way_q ? way1_rsp : way0_rsp;

   // hit way during compare, chosen way afterwards
   assign data_out = ((state == S_COMP) ? way1_rsp.hit : way_q) ? way1_rsp.data : way0_rsp.data;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state     <= S_IDLE;
         rd_q      <= 1'b0;
         wr_q      <= 1'b0;
         victim_q  <= 1'b0;
         way_q     <= 1'b0;
         issue_cnt <= '0;
         fill_cnt  <= '0;
      end else begin
         state    <= state_nxt;
         victim_q <= victim_q ^ accept;
         if (accept) begin
            rd_q <= rd;
            wr_q <= wr;
         end
         if (state == S_COMP) begin
            way_q     <= way_pick;
            issue_cnt <= '0;
            fill_cnt  <= '0;
         end else begin
            if (mem_go) begin
               // writeback wraps to zero so the fill starts at word 0
               issue_cnt <= (state == S_WB && issue_last) ? '0 : issue_cnt + 1'b1;
            end
            if (state == S_ALLOC && mem_rsp.rd_valid) begin
               fill_cnt <= fill_cnt + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         addr_q <= addr;
         data_q <= data_in;
      end
   end

   always_comb begin
      state_nxt        = state;
      way_req.comp     = 1'b0;
      way_req.write    = 1'b0;
      way_req.valid_in = 1'b1;
      way_req.tag      = addr_q.fields.tag;
      way_req.index    = addr_q.fields.index;
      way_req.offset   = addr_q.fields.offset;
      way_req.data     = data_q;
      way0_en          = 1'b0;
      way1_en          = 1'b0;
      mem_req.rd       = 1'b0;
      mem_req.wr       = 1'b0;
      mem_req.addr     = addr_q;
      mem_req.data     = sel_rsp.data;
      done             = 1'b0;
      cache_hit        = 1'b0;
      err              = 1'b0;

      case (state)
         S_IDLE: begin
            if (accept) begin
               state_nxt = addr.raw[0] ? S_ERR : S_COMP;
            end
         end
         S_ERR: begin
            err       = 1'b1;
            state_nxt = S_IDLE;
         end
         S_COMP: begin
            way0_en       = rd_q | wr_q;
            way1_en       = rd_q | wr_q;
            way_req.comp  = 1'b1;
            way_req.write = wr_q;
            cache_hit     = any_hit;
            done          = any_hit;
            if (any_hit) begin
               state_nxt = S_IDLE;
            end else if (way_pick ? way1_rsp.dirty : way0_rsp.dirty) begin
               state_nxt = S_WB;
            end else begin
               state_nxt = S_ALLOC;
            end
         end
         S_WB: begin
            // victim word goes out to its own tag at this index
            way_req.offset              = {issue_cnt[WSEL_W-1:0], 1'b0};
            mem_req.wr                  = 1'b1;
            mem_req.addr.fields.tag     = sel_rsp.tag;
            mem_req.addr.fields.offset  = {issue_cnt[WSEL_W-1:0], 1'b0};
            if (mem_go && issue_last) begin
               state_nxt = S_ALLOC;
            end
         end
         S_ALLOC: begin
            way0_en                    = ~way_q;
            way1_en                    = way_q;
            way_req.write              = mem_rsp.rd_valid;
            way_req.offset             = {fill_cnt, 1'b0};
            way_req.data               = mem_rsp.rd_data;
            mem_req.rd                 = ~issue_cnt[WSEL_W];
            mem_req.addr.fields.offset = {issue_cnt[WSEL_W-1:0], 1'b0};
            if (mem_rsp.rd_valid && fill_last) begin
               state_nxt = S_FCOMP;
            end
         end
         S_FCOMP: begin
            // line is resident now, a write lands as a compare hit
            way0_en       = ~way_q;
            way1_en       = way_q;
            way_req.comp  = 1'b1;
            way_req.write = wr_q;
            state_nxt     = S_DONE;
         end
         S_DONE: begin
            done      = 1'b1;
            state_nxt = S_IDLE;
         end
         default: begin
            state_nxt = S_IDLE;
         end
      endcase
   end

endmodule

`default_nettype wire

/* cache_way.sv */
/*
 * one cache way: tag, valid, dirty and data arrays with tag compare,
 * compare writes on a hit and fill writes that install a new line
 */
`timescale 1ns/1ns
`default_nettype none

module cache_way (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   en,
   input  mem_sys_pkg::cache_req_t req,
   output mem_sys_pkg::way_rsp_t   rsp
);
   import mem_sys_pkg::*;

   localparam int SETS   = 2 ** IDX_W;
   localparam int WSEL_W = $clog2(LINE_WORDS);

   logic [TAG_W-1:0]  tag_arr [SETS];
   logic [WORD_W-1:0] data_arr [SETS][LINE_WORDS];
   logic [SETS-1:0]   valid_r;
   logic [SETS-1:0]   dirty_r;
   logic [WSEL_W-1:0] word;
   logic              tag_match;
   logic              cmp_wr;
   logic              fill_wr;

   // word within the line, offset bit 0 is the byte select
   assign word      = req.offset[OFS_W-1:1];
   assign tag_match = (tag_arr[req.index] == req.tag);

   // reads are combinational at index and offset
   assign rsp.hit   = en & valid_r[req.index] & tag_match;
   assign rsp.valid = valid_r[req.index];
   assign rsp.dirty = dirty_r[req.index];
   assign rsp.tag   = tag_arr[req.index];
   assign rsp.data  = data_arr[req.index][word];

   // compare write only lands on a hit
   assign cmp_wr  = en & req.write & req.comp & rsp.hit;
   assign fill_wr = en & req.write & ~req.comp;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_r <= '0;
         dirty_r <= '0;
      end else begin
         if (fill_wr) begin
            valid_r[req.index] <= req.valid_in;
            dirty_r[req.index] <= 1'b0;
         end else if (cmp_wr) begin
            dirty_r[req.index] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (cmp_wr || fill_wr) begin
         data_arr[req.index][word] <= req.data;
      end
      // a fill installs the new tag with the first word
      if (fill_wr) begin
         tag_arr[req.index] <= req.tag;
      end
   end

endmodule

`default_nettype wire

/* list.f */
mem_sys_pkg.sv
cache_way.sv
bank_mem.sv
cache_ctrl.sv
mem_system.sv
mem_system_assert.sv
mem_system_tb.sv

/* mem_sys_pkg.sv */
/*
 * shared types for the two-way data cache and its banked main memory
 */
`default_nettype none

package mem_sys_pkg;

   // address geometry
   localparam int TAG_W      = 5;
   localparam int IDX_W      = 8;
   localparam int OFS_W      = 3;
   localparam int ADDR_W     = TAG_W + IDX_W + OFS_W;
   localparam int WORD_W     = 16;
   localparam int LINE_WORDS = 4;
   localparam int MEM_RD_LAT = 2;

   typedef struct packed {
      logic [TAG_W-1:0] tag;
      logic [IDX_W-1:0] index;
      logic [OFS_W-1:0] offset;
   } addr_fields_t;

   // byte address, seen raw or split into tag, index and offset
   typedef union packed {
      logic [ADDR_W-1:0] raw;
      addr_fields_t      fields;
   } addr_u;

   typedef struct packed {
      logic              comp;
      logic              write;
      logic              valid_in;
      logic [TAG_W-1:0]  tag;
      logic [IDX_W-1:0]  index;
      logic [OFS_W-1:0]  offset;
      logic [WORD_W-1:0] data;
   } cache_req_t;

   typedef struct packed {
      logic              hit;
      logic              valid;
      logic              dirty;
      logic [TAG_W-1:0]  tag;
      logic [WORD_W-1:0] data;
   } way_rsp_t;

   typedef struct packed {
      logic              rd;
      logic              wr;
      addr_u             addr;
      logic [WORD_W-1:0] data;
   } mem_req_t;

   typedef struct packed {
      logic              stall;
      logic              rd_valid;
      logic [WORD_W-1:0] rd_data;
   } mem_rsp_t;

endpackage

`default_nettype wire

/* mem_system.sv */
/*
 * memory system top: cache controller, two cache ways and banked memory
 */
`timescale 1ns/1ns
`default_nettype none

module mem_system #(
   parameter int BANK_BUSY = 4
) (
   input  logic                           clk,
   input  logic                           arst_n,
   input  mem_sys_pkg::addr_u             addr,
   input  logic [mem_sys_pkg::WORD_W-1:0] data_in,
   input  logic                           rd,
   input  logic                           wr,
   output logic [mem_sys_pkg::WORD_W-1:0] data_out,
   output logic                           done,
   output logic                           stall,
   output logic                           cache_hit,
   output logic                           err
);
   import mem_sys_pkg::*;

   cache_req_t way_req;
   logic       way0_en;
   logic       way1_en;
   way_rsp_t   way0_rsp;
   way_rsp_t   way1_rsp;
   mem_req_t   mem_req;
   mem_rsp_t   mem_rsp;

   cache_ctrl ctrl_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err),
      .way_req   (way_req),
      .way0_en   (way0_en),
      .way1_en   (way1_en),
      .way0_rsp  (way0_rsp),
      .way1_rsp  (way1_rsp),
      .mem_req   (mem_req),
      .mem_rsp   (mem_rsp)
   );

   // both ways see the same request, enables pick who writes
   cache_way way0_i (
      .clk    (clk),
      .arst_n (arst_n),
      .en     (way0_en),
      .req    (way_req),
      .rsp    (way0_rsp)
   );

   cache_way way1_i (
      .clk    (clk),
      .arst_n (arst_n),
      .en     (way1_en),
      .req    (way_req),
      .rsp    (way1_rsp)
   );

   bank_mem #(
      .BANK_BUSY (BANK_BUSY)
   ) mem_i (
      .clk    (clk),
      .arst_n (arst_n),
      .req    (mem_req),
      .rsp    (mem_rsp)
   );

endmodule

`default_nettype wire

/* mem_system_assert.sv */
/*
 * protocol assertions on the memory system top-level strobes
 */
`timescale 1ns/1ns
`default_nettype none

module mem_system_assert (
   input logic clk,
   input logic arst_n,
   input logic rd,
   input logic wr,
   input logic stall,
   input logic done,
   input logic err,
   input logic mem_rd,
   input logic mem_wr
);

   done_err_excl: assert property (@(posedge clk) disable iff (!arst_n) !(done && err))
      else $error("done and err are high in the same cycle");

   // done is a single-cycle pulse
   done_pulse: assert property (@(posedge clk) disable iff (!arst_n) done |=> !done)
      else $error("done stayed high for more than one cycle");

   mem_rw_excl: assert property (@(posedge clk) disable iff (!arst_n) !(mem_rd && mem_wr))
      else $error("memory read and write are high together");

   stall_after_accept: assert property (@(posedge clk) disable iff (!arst_n)
      (rd || wr) && !stall |=> stall)
      else $error("stall is low in the cycle after an accepted request");

endmodule

bind mem_system mem_system_assert assert_i (
   .clk    (clk),
   .arst_n (arst_n),
   .rd     (rd),
   .wr     (wr),
   .stall  (stall),
   .done   (done),
   .err    (err),
   .mem_rd (mem_req.rd),
   .mem_wr (mem_req.wr)
);

`default_nettype wire

/* mem_system_tb.sv */
/*
 * directed testbench for the two-way cache memory system,
 * checked against a shadow word array of main memory
 */
`timescale 1ns/1ns
`default_nettype none

module mem_system_tb;
   import mem_sys_pkg::*;

   localparam int TIMEOUT = 200;

   logic              clk;
   logic              arst_n;
   addr_u             addr;
   logic [WORD_W-1:0] data_in;
   logic              rd;
   logic              wr;
   logic [WORD_W-1:0] data_out;
   logic              done;
   logic              stall;
   logic              cache_hit;
   logic              err;
   logic [WORD_W-1:0] shadow [2**(ADDR_W-1)];
   integer            seed;

   mem_system #(
      .BANK_BUSY (4)
   ) mem_system_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   always #2 clk = ~clk;

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("MISMATCH %s got %h expected %h", name, got, exp);
         $display("Test failed");
         $fatal(1, "stopped at the first mismatch");
      end
   endtask

   task automatic report_timeout(input string what);
      $display("timeout while waiting for %s", what);
      $display("Test failed");
      $fatal(1, "stopped on a timeout");
   endtask

   function automatic addr_u line_addr(input int tag, input int index, input int word);
      addr_u a;
      a.fields.tag    = TAG_W'(tag);
      a.fields.index  = IDX_W'(index);
      a.fields.offset = {word[1:0], 1'b0};
      return a;
   endfunction

   // waits for idle, then holds the request over one accepting edge
   task automatic issue_request(input addr_u a, input logic r, input logic w,
                                input logic [WORD_W-1:0] d);
      int n;
      n = 0;
      @(negedge clk);
      while (stall) begin
         n++;
         if (n > TIMEOUT) report_timeout("stall to drop");
         @(negedge clk);
      end
      @(posedge clk);
      addr    <= a;
      rd      <= r;
      wr      <= w;
      data_in <= d;
      @(posedge clk);
      rd <= 1'b0;
      wr <= 1'b0;
   endtask

   // cycles counted from the accepting edge to done or err
   task automatic wait_for_end(output int cycles);
      cycles = 1;
      @(negedge clk);
      while (!done && !err) begin
         cycles++;
         if (cycles > TIMEOUT) report_timeout("done or err");
         @(negedge clk);
      end
      // stall still covers the done or err cycle
      check("stall", stall, 1);
   endtask

   // exp_hit of -1 leaves cache_hit unchecked
   task automatic do_read(input addr_u a, input int exp_hit);
      int cycles;
      issue_request(a, 1'b1, 1'b0, '0);
      wait_for_end(cycles);
      check("done", done, 1);
      check("err", err, 0);
      check("data_out", data_out, shadow[a.raw[ADDR_W-1:1]]);
      if (exp_hit >= 0) begin
         check("cache_hit", cache_hit, exp_hit);
      end
      if (exp_hit == 1) begin
         check("hit latency", cycles, 1);
      end
      @(negedge clk);
      check("stall", stall, 0);
   endtask

   task automatic do_write(input addr_u a, input logic [WORD_W-1:0] d, input int exp_hit);
      int cycles;
      issue_request(a, 1'b0, 1'b1, d);
      wait_for_end(cycles);
      check("done", done, 1);
      check("err", err, 0);
      shadow[a.raw[ADDR_W-1:1]] = d;
      if (exp_hit >= 0) begin
         check("cache_hit", cache_hit, exp_hit);
      end
      @(negedge clk);
      check("stall", stall, 0);
   endtask

   // odd address write that must not land anywhere
   task automatic do_bad(input addr_u a);
      int cycles;
      issue_request(a, 1'b0, 1'b1, ~shadow[a.raw[ADDR_W-1:1]]);
      wait_for_end(cycles);
      check("err", err, 1);
      check("done", done, 0);
      check("err latency", cycles, 1);
      @(negedge clk);
      check("err", err, 0);
      check("done", done, 0);
      check("stall", stall, 0);
   endtask

   task automatic reset_and_cold_miss();
      @(negedge clk);
      check("stall", stall, 0);
      check("done", done, 0);
      check("cache_hit", cache_hit, 0);
      check("err", err, 0);
      do_read(line_addr(1, 8'h10, 2), 0);
      do_read(line_addr(3, 8'h20, 0), 0);
   endtask

   task automatic write_then_hit();
      do_write(line_addr(2, 8'h30, 1), 16'h1234, 0);
      do_read(line_addr(2, 8'h30, 1), 1);
      for (int w = 0; w < LINE_WORDS; w++) begin
         do_write(line_addr(2, 8'h30, w), 16'h5a00 + WORD_W'(w), 1);
         do_read(line_addr(2, 8'h30, w), 1);
      end
   endtask

   task automatic two_ways_per_set();
      do_write(line_addr(4, 8'h40, 0), 16'ha4a4, 0);
      do_write(line_addr(5, 8'h40, 0), 16'hb5b5, 0);
      do_read(line_addr(4, 8'h40, 0), 1);
      do_read(line_addr(5, 8'h40, 0), 1);
   endtask

   // both resident lines are dirty, so the third tag forces a writeback
   task automatic dirty_eviction();
      do_write(line_addr(6, 8'h40, 3), 16'hc6c6, -1);
      do_read(line_addr(4, 8'h40, 0), -1);
      do_read(line_addr(5, 8'h40, 0), -1);
      do_read(line_addr(6, 8'h40, 3), -1);
   endtask

   task automatic misaligned_access();
      addr_u a;
      a = line_addr(7, 8'h50, 2);
      do_write(a, 16'h7777, 0);
      a.raw[0] = 1'b1;
      do_bad(a);
      a.raw[0] = 1'b0;
      do_read(a, 1);
   endtask

   task automatic random_mix();
      addr_u a;
      addr_u prev;
      logic  have_prev;
      int    exp_hit;
      int    r;
      have_prev = 1'b0;
      prev      = '0;
      for (int i = 0; i < 200; i++) begin
         r = $random(seed);
         a = line_addr(9 + ((r >> 8) & 8'hff) % 3, 8'h60 + (r & 3), (r >> 2) & 3);
         exp_hit = (have_prev && a.raw[ADDR_W-1:3] == prev.raw[ADDR_W-1:3]) ? 1 : -1;
         if (r[4]) begin
            do_write(a, WORD_W'($random(seed)), exp_hit);
         end else begin
            do_read(a, exp_hit);
         end
         prev      = a;
         have_prev = 1'b1;
      end
   endtask

   initial begin
      seed    = 32'h4169;
      clk     = 1'b0;
      arst_n  = 1'b0;
      addr    = '0;
      data_in = '0;
      rd      = 1'b0;
      wr      = 1'b0;
      for (int i = 0; i < 2**(ADDR_W-1); i++) begin
         shadow[i] = '0;
      end
      repeat (10) @(posedge clk);
      arst_n <= 1'b1;
      reset_and_cold_miss();
      write_then_hit();
      two_ways_per_set();
      dirty_eviction();
      misaligned_access();
      random_mix();
      $display("Test passed");
      $finish;
   end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build the cache memory system simulation with Verilator and run it
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module mem_system_tb \
   -f list.f -o mem_system_sim \
   && ./obj_dir/mem_system_sim 2>&1 | tee sim.log
grep -q "^Test passed$" sim.log \
   && echo "simulation passed" \
   || { echo "simulation did not pass"; exit 1; }
